//--- src.f
design/task_bridge_pkg.sv
design/mmio_decode.sv
design/task_sequencer.sv
design/enqueue_stager.sv
design/undo_log_writer.sv
design/task_bridge.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_task_bridge.sv

//--- test/tb_task_bridge.sv
`default_nettype none

module tb_task_bridge;
   timeunit 1ns;
   timeprecision 100ps;
   import task_bridge_pkg::*;

   localparam int NUM_TASKS = 40;
   localparam int WATCHDOG_NS = 200 * NUM_TASKS * 8;

   logic                     clk, rstn;
   logic                     cmd_valid, cmd_ready, rsp_valid;
   dbus_cmd_t                cmd;
   logic [31:0]              rsp_data;
   logic                     task_arvalid, task_rvalid, start_task_valid, start_task_ready;
   task_t                    task_rdata, task_wdata;
   logic [SLOT_WIDTH-1:0]    task_rslot, start_task_slot, task_cq_slot;
   logic [SLOT_WIDTH-1:0]    finish_task_slot, undo_log_slot;
   logic [THREAD_WIDTH-1:0]  task_rthread, finish_task_thread;
   logic                     task_wvalid, task_wready, finish_task_valid, finish_task_ready;
   logic [CHILD_WIDTH-1:0]   task_child_id, finish_task_num_children;
   logic                     finish_task_undo_log_write, undo_log_valid, undo_log_ready;
   logic [UNDO_ID_WIDTH-1:0] undo_log_id;
   logic [31:0]              undo_log_addr, undo_log_data;
   int                       errors, tasks_done;
   integer                   seed = 86871;
   integer                   queue_seed = 86872;
   logic                     staged_all, rdata_taken;

   tb_clock clock_gen (.clk(clk), .rstn(rstn));

   task_bridge UUT (.*);

   tb_checker scoreboard (.*);

   function automatic logic [31:0] read_field_addr(input logic [2:0] pick);
      case (pick)
         3'd0: return ADDR_TASK_LOCALE;
         3'd1: return ADDR_TASK_TTYPE;
         3'd2: return ADDR_TASK_ARG0;
         3'd3: return ADDR_TASK_ARG1;
         default: return ADDR_CUR_CYCLE;
      endcase
   endfunction

   // one command, held until taken; a read also waits for its response
   task automatic bus_op(input logic wr, input logic [31:0] addr, input logic [31:0] data);
      logic [31:0] r;
      r = $random(seed);
      repeat (1 + int'(r[1:0])) @(negedge clk);
      cmd_valid = 1'b1;
      cmd.wr = wr;
      cmd.addr = addr;
      cmd.data = data;
      @(posedge clk);
      while (!cmd_ready) @(posedge clk);
      @(negedge clk);
      cmd_valid = 1'b0;
      if (!wr) begin
         while (!rsp_valid) @(posedge clk);
      end
   endtask

   task automatic enqueue_child();
      logic [31:0] r;
      r = $random(seed);
      if (!staged_all || r[0]) bus_op(1'b1, ADDR_TASK_LOCALE, $random(seed));
      if (!staged_all || r[1]) bus_op(1'b1, ADDR_TASK_TTYPE, $random(seed));
      if (!staged_all || r[2]) bus_op(1'b1, ADDR_TASK_ARG0, $random(seed));
      if (!staged_all || r[3]) bus_op(1'b1, ADDR_TASK_ARG1, $random(seed));
      staged_all = 1'b1;
      bus_op(1'b1, ADDR_TASK_TS, $random(seed));
   endtask

   task automatic run_task_sequence();
      logic [31:0] r;
      r = $random(seed);
      bus_op(1'b0, ADDR_TASK_TS, '0);
      repeat (2 + int'(r[2:0])) begin
         r = $random(seed);
         case (r[2:0])
            3'd0, 3'd1: bus_op(1'b0, read_field_addr(r[6:4]), '0);
            3'd2: bus_op(1'b0, {2'b00, r[31:2]}, '0);
            3'd3: bus_op(1'b1, {2'b01, r[31:2]}, r);
            3'd4, 3'd5: enqueue_child();
            default: begin
               bus_op(1'b1, ADDR_UNDO_ADDR, $random(seed));
               bus_op(1'b1, ADDR_UNDO_DATA, $random(seed));
            end
         endcase
      end
      bus_op(1'b1, ADDR_FINISH_TASK, '0);
   endtask

   always @(posedge clk) rdata_taken <= task_arvalid & task_rvalid;

   // queue side keeps an offered task until it is taken
   always @(negedge clk) begin : queue_side
      logic [31:0] r;
      r = $random(queue_seed);
      start_task_ready = r[1] | r[2];
      task_wready = r[3] | r[4];
      finish_task_ready = r[5] | r[6];
      undo_log_ready = r[7] | r[8];
      if (!task_rvalid || rdata_taken) begin
         task_rvalid = r[0];
         task_rslot = r[14:9];
         task_rthread = r[18:15];
         task_rdata.ttype = r[22:19];
         task_rdata.ts = $random(queue_seed);
         task_rdata.locale = $random(queue_seed);
         task_rdata.args.word = {$random(queue_seed), $random(queue_seed)};
      end
   end

   initial begin
      cmd_valid = 1'b0;
      cmd = '0;
      task_rvalid = 1'b0;
      task_rdata = '0;
      task_rslot = '0;
      task_rthread = '0;
      start_task_ready = 1'b0;
      task_wready = 1'b0;
      finish_task_ready = 1'b0;
      undo_log_ready = 1'b0;
      staged_all = 1'b0;
      rdata_taken = 1'b0;
      @(posedge rstn);
      repeat (NUM_TASKS) run_task_sequence();
      repeat (4) @(negedge clk);
      $display("%0d of %0d tasks finished, %0d errors", tasks_done, NUM_TASKS, errors);
      if (errors == 0 && tasks_done == NUM_TASKS) begin
         $display("TEST OK");
      end else begin
         if (tasks_done != NUM_TASKS) begin
            $display("only %0d of %0d finish reports were seen", tasks_done, NUM_TASKS);
         end
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the run did not complete within %0d ns", WATCHDOG_NS);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- test/tb_checker.sv
`default_nettype none

module tb_checker (
   input  logic                                      clk,
   input  logic                                      rstn,
   input  logic                                      cmd_valid,
   input  task_bridge_pkg::dbus_cmd_t                cmd,
   input  logic                                      cmd_ready,
   input  logic                                      rsp_valid,
   input  logic [31:0]                               rsp_data,
   input  logic                                      task_arvalid,
   input  logic                                      task_rvalid,
   input  task_bridge_pkg::task_t                    task_rdata,
   input  logic [task_bridge_pkg::SLOT_WIDTH-1:0]    task_rslot,
   input  logic [task_bridge_pkg::THREAD_WIDTH-1:0]  task_rthread,
   input  logic                                      start_task_valid,
   input  logic [task_bridge_pkg::SLOT_WIDTH-1:0]    start_task_slot,
   input  logic                                      start_task_ready,
   input  logic                                      task_wvalid,
   input  task_bridge_pkg::task_t                    task_wdata,
   input  logic [task_bridge_pkg::SLOT_WIDTH-1:0]    task_cq_slot,
   input  logic [task_bridge_pkg::CHILD_WIDTH-1:0]   task_child_id,
   input  logic                                      task_wready,
   input  logic                                      finish_task_valid,
   input  logic [task_bridge_pkg::SLOT_WIDTH-1:0]    finish_task_slot,
   input  logic [task_bridge_pkg::THREAD_WIDTH-1:0]  finish_task_thread,
   input  logic [task_bridge_pkg::CHILD_WIDTH-1:0]   finish_task_num_children,
   input  logic                                      finish_task_undo_log_write,
   input  logic                                      finish_task_ready,
   input  logic                                      undo_log_valid,
   input  logic [task_bridge_pkg::UNDO_ID_WIDTH-1:0] undo_log_id,
   input  logic [31:0]                               undo_log_addr,
   input  logic [31:0]                               undo_log_data,
   input  logic [task_bridge_pkg::SLOT_WIDTH-1:0]    undo_log_slot,
   input  logic                                      undo_log_ready,
   output int                                        errors,
   output int                                        tasks_done
);
   timeunit 1ns;
   timeprecision 100ps;
   import task_bridge_pkg::*;

   task_t                    cur_task;
   task_t                    staged;
   logic [SLOT_WIDTH-1:0]    cur_slot;
   logic [THREAD_WIDTH-1:0]  cur_thread;
   logic [CHILD_WIDTH-1:0]   children;
   logic [UNDO_ID_WIDTH-1:0] undo_id;
   logic                     undo_flag;
   logic [31:0]              undo_addr;
   logic [31:0]              undo_data;
   logic [31:0]              cycle;
   logic [31:0]              last_cycle;
   logic [31:0]              rsp_expect;
   logic                     rsp_due;
   logic                     rsp_cycle;
   logic                     deq_due;
   logic                     started;
   logic                     leaving_reset;

   initial begin
      errors = 0;
      tasks_done = 0;
   end

   task automatic check(input logic ok, input string msg);
      if (ok !== 1'b1) begin
         errors++;
         $display("** Error at time %0t: %s", $time, msg);
      end
   endtask

   always @(posedge clk) begin
      if (!rstn) begin
         cycle = '0;
         last_cycle = '0;
         rsp_due = 1'b0;
         rsp_cycle = 1'b0;
         deq_due = 1'b0;
         started = 1'b0;
         leaving_reset = 1'b1;
      end else begin
         if (leaving_reset) begin
            check({cmd_ready, rsp_valid, task_arvalid, start_task_valid, task_wvalid,
                   finish_task_valid, undo_log_valid} === 7'd0,
                  "an output valid or ready is high right after reset");
            leaving_reset = 1'b0;
         end

         // field reads answer one cycle after acceptance, dequeues after the start
         if (rsp_due) begin
            check(rsp_valid, "no read response one cycle after acceptance");
            check(rsp_data === rsp_expect,
                  $sformatf("read data %0h, expected %0h", rsp_data, rsp_expect));
            if (rsp_cycle) begin
               check(rsp_data > last_cycle, "cycle reads did not increase");
               last_cycle = rsp_data;
            end
            rsp_due = 1'b0;
         end else if (rsp_valid) begin
            check(deq_due, "read response with no read outstanding");
            check(started, "dequeue response came before the start transfer");
            check(rsp_data === cur_task.ts,
                  $sformatf("dequeue ts %0h, expected %0h", rsp_data, cur_task.ts));
            deq_due = 1'b0;
         end

         if (task_arvalid && task_rvalid) begin
            cur_task = task_rdata;
            cur_slot = task_rslot;
            cur_thread = task_rthread;
            children = '0;
            undo_id = '0;
            undo_flag = 1'b0;
            started = 1'b0;
         end
         if (start_task_valid && start_task_ready) begin
            check(start_task_slot === cur_slot,
                  $sformatf("start slot %0d, expected %0d", start_task_slot, cur_slot));
            started = 1'b1;
         end
         if (task_wvalid && task_wready) begin
            check(task_wdata === staged,
                  $sformatf("enqueued task %0h, expected %0h", task_wdata, staged));
            check(task_cq_slot === cur_slot,
                  $sformatf("enqueue slot %0d, expected %0d", task_cq_slot, cur_slot));
            check(task_child_id === children,
                  $sformatf("child id %0d, expected %0d", task_child_id, children));
            children = children + 1'b1;
         end
         if (undo_log_valid && undo_log_ready) begin
            check(undo_log_addr === undo_addr && undo_log_data === undo_data,
                  $sformatf("undo entry %0h/%0h, expected %0h/%0h", undo_log_addr,
                            undo_log_data, undo_addr, undo_data));
            check(undo_log_slot === cur_slot,
                  $sformatf("undo slot %0d, expected %0d", undo_log_slot, cur_slot));
            check(undo_log_id === undo_id,
                  $sformatf("undo id %0d, expected %0d", undo_log_id, undo_id));
            undo_id = undo_id + 1'b1;
            undo_flag = 1'b1;
         end
         if (finish_task_valid && finish_task_ready) begin
            check(finish_task_slot === cur_slot && finish_task_thread === cur_thread,
                  $sformatf("finish slot/thread %0d/%0d, expected %0d/%0d",
                            finish_task_slot, finish_task_thread, cur_slot, cur_thread));
            check(finish_task_num_children === children,
                  $sformatf("finish children %0d, expected %0d",
                            finish_task_num_children, children));
            check(finish_task_undo_log_write === undo_flag,
                  $sformatf("finish undo flag %0b, expected %0b",
                            finish_task_undo_log_write, undo_flag));
            tasks_done++;
            $display("task %0d finished: slot %0d, %0d children, undo %0b, errors %0d",
                     tasks_done, cur_slot, children, undo_flag, errors);
         end

         if (cmd_valid && cmd_ready && !cmd.wr) begin
            if (cmd.addr == ADDR_TASK_TS) begin
               deq_due = 1'b1;
            end else begin
               rsp_due = 1'b1;
               rsp_cycle = (cmd.addr == ADDR_CUR_CYCLE);
               case (cmd.addr)
                  ADDR_TASK_LOCALE: rsp_expect = cur_task.locale;
                  ADDR_TASK_TTYPE: rsp_expect = 32'(cur_task.ttype);
                  ADDR_TASK_ARG0: rsp_expect = cur_task.args.word[31:0];
                  ADDR_TASK_ARG1: rsp_expect = cur_task.args.word[63:32];
                  ADDR_CUR_CYCLE: rsp_expect = cycle;
                  default: rsp_expect = '0;
               endcase
            end
         end else if (cmd_valid && cmd_ready) begin
            case (cmd.addr)
               ADDR_TASK_LOCALE: staged.locale = cmd.data;
               ADDR_TASK_TTYPE: staged.ttype = cmd.data[TTYPE_WIDTH-1:0];
               ADDR_TASK_ARG0: staged.args.word[31:0] = cmd.data;
               ADDR_TASK_ARG1: staged.args.word[63:32] = cmd.data;
               ADDR_TASK_TS: staged.ts = cmd.data;
               ADDR_UNDO_ADDR: undo_addr = cmd.data;
               ADDR_UNDO_DATA: undo_data = cmd.data;
               ADDR_FINISH_TASK: check(finish_task_valid && finish_task_ready,
                                       "finish write accepted without a finish transfer");
               default: ;
            endcase
         end
         cycle = cycle + 32'd1;
      end
   end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`default_nettype none

module tb_clock (
   output logic clk,
   output logic rstn
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // reset held low over the first two rising edges
   initial begin
      rstn = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
   end

endmodule

`default_nettype wire

//--- design/task_bridge.sv
`default_nettype none

module task_bridge (
   input  logic                                      clk,
   input  logic                                      rstn,
   input  logic                                      cmd_valid,
   input  task_bridge_pkg::dbus_cmd_t                cmd,
   output logic                                      cmd_ready,
   output logic                                      rsp_valid,
   output logic [31:0]                               rsp_data,
   output logic                                      task_arvalid,
   input  logic                                      task_rvalid,
   input  task_bridge_pkg::task_t                    task_rdata,
   input  logic [task_bridge_pkg::SLOT_WIDTH-1:0]    task_rslot,
   input  logic [task_bridge_pkg::THREAD_WIDTH-1:0]  task_rthread,
   output logic                                      start_task_valid,
   output logic [task_bridge_pkg::SLOT_WIDTH-1:0]    start_task_slot,
   input  logic                                      start_task_ready,
   output logic                                      task_wvalid,
   output task_bridge_pkg::task_t                    task_wdata,
   output logic [task_bridge_pkg::SLOT_WIDTH-1:0]    task_cq_slot,
   output logic [task_bridge_pkg::CHILD_WIDTH-1:0]   task_child_id,
   input  logic                                      task_wready,
   output logic                                      finish_task_valid,
   output logic [task_bridge_pkg::SLOT_WIDTH-1:0]    finish_task_slot,
   output logic [task_bridge_pkg::THREAD_WIDTH-1:0]  finish_task_thread,
   output logic [task_bridge_pkg::CHILD_WIDTH-1:0]   finish_task_num_children,
   output logic                                      finish_task_undo_log_write,
   input  logic                                      finish_task_ready,
   output logic                                      undo_log_valid,
   output logic [task_bridge_pkg::UNDO_ID_WIDTH-1:0] undo_log_id,
   output logic [31:0]                               undo_log_addr,
   output logic [31:0]                               undo_log_data,
   output logic [task_bridge_pkg::SLOT_WIDTH-1:0]    undo_log_slot,
   input  logic                                      undo_log_ready
);
   import task_bridge_pkg::*;

   mmio_target_e             target;
   logic                     seq_ready;
   logic                     enq_ready;
   logic                     undo_ready;
   logic                     read_accept;
   logic                     dequeued;
   logic [SLOT_WIDTH-1:0]    cq_slot;
   logic                     enq_pending;
   logic                     undo_pending;
   logic [CHILD_WIDTH-1:0]   child_count;
   logic                     undo_written;

   // port names line up across the units
   mmio_decode u_decode (.*);

   task_sequencer u_sequencer (.*);

   enqueue_stager u_enqueue (.*);

   undo_log_writer u_undo (.*);

endmodule

`default_nettype wire

//--- design/undo_log_writer.sv
`default_nettype none

module undo_log_writer (
   input  logic                                      clk,
   input  logic                                      rstn,
   input  logic                                      cmd_valid,
   input  task_bridge_pkg::dbus_cmd_t                cmd,
   input  task_bridge_pkg::mmio_target_e             target,
   input  logic                                      dequeued,
   input  logic [task_bridge_pkg::SLOT_WIDTH-1:0]    cq_slot,
   input  logic                                      undo_log_ready,
   output logic                                      undo_ready,
   output logic                                      undo_pending,
   output logic                                      undo_written,
   output logic                                      undo_log_valid,
   output logic [task_bridge_pkg::UNDO_ID_WIDTH-1:0] undo_log_id,
   output logic [31:0]                               undo_log_addr,
   output logic [31:0]                               undo_log_data,
   output logic [task_bridge_pkg::SLOT_WIDTH-1:0]    undo_log_slot
);
   import task_bridge_pkg::*;

   logic undo_take;
   logic undo_sent;

   assign undo_ready = !undo_log_valid;
   assign undo_pending = undo_log_valid;
   assign undo_take = cmd_valid & undo_ready;
   assign undo_sent = undo_log_valid & undo_log_ready;
   assign undo_log_slot = cq_slot;

   always_ff @(posedge clk) begin
      if (undo_take & (target == UNDO_ADDR)) begin
         undo_log_addr <= cmd.data;
      end
      if (undo_take & (target == UNDO_DATA)) begin
         undo_log_data <= cmd.data;
      end
   end

   // the data write completes the entry
   always_ff @(posedge clk) begin
      if (!rstn) begin
         undo_log_valid <= 1'b0;
      end else if (undo_take & (target == UNDO_DATA)) begin
         undo_log_valid <= 1'b1;
      end else if (undo_log_ready) begin
         undo_log_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         undo_log_id <= '0;
         undo_written <= 1'b0;
      end else if (dequeued) begin
         undo_log_id <= '0;
         undo_written <= 1'b0;
      end else if (undo_sent) begin
         undo_log_id <= undo_log_id + 1'b1;
         undo_written <= 1'b1;
      end
   end

   entry_hold: assert property (@(posedge clk) disable iff (!rstn)
      undo_log_valid && !undo_log_ready |=>
         undo_log_valid && $stable(undo_log_addr) && $stable(undo_log_data));

endmodule

`default_nettype wire

//--- design/enqueue_stager.sv
`default_nettype none

module enqueue_stager (
   input  logic                                    clk,
   input  logic                                    rstn,
   input  logic                                    cmd_valid,
   input  task_bridge_pkg::dbus_cmd_t              cmd,
   input  task_bridge_pkg::mmio_target_e           target,
   input  logic                                    dequeued,
   input  logic [task_bridge_pkg::SLOT_WIDTH-1:0]  cq_slot,
   input  logic                                    task_wready,
   output logic                                    enq_ready,
   output logic                                    enq_pending,
   output logic [task_bridge_pkg::CHILD_WIDTH-1:0] child_count,
   output logic                                    task_wvalid,
   output task_bridge_pkg::task_t                  task_wdata,
   output logic [task_bridge_pkg::SLOT_WIDTH-1:0]  task_cq_slot,
   output logic [task_bridge_pkg::CHILD_WIDTH-1:0] task_child_id
);
   import task_bridge_pkg::*;

   logic stage_wr;

   // staged fields are frozen while the enqueue waits
   assign enq_ready = !task_wvalid;
   assign enq_pending = task_wvalid;
   assign stage_wr = cmd_valid & enq_ready;

   always_ff @(posedge clk) begin
      if (stage_wr & (target == FIELD_WRITE)) begin
         case (cmd.addr)
            ADDR_TASK_LOCALE: task_wdata.locale <= cmd.data;
            ADDR_TASK_TTYPE: task_wdata.ttype <= cmd.data[TTYPE_WIDTH-1:0];
            ADDR_TASK_ARG0: task_wdata.args.half.lo <= cmd.data;
            ADDR_TASK_ARG1: task_wdata.args.half.hi <= cmd.data;
            default: ;
         endcase
      end else if (stage_wr & (target == ENQUEUE)) begin
         task_wdata.ts <= cmd.data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_wvalid <= 1'b0;
      end else if (stage_wr & (target == ENQUEUE)) begin
         task_wvalid <= 1'b1;
      end else if (task_wready) begin
         task_wvalid <= 1'b0;
      end
   end

   // children are numbered from zero within each dequeued task
   always_ff @(posedge clk) begin
      if (!rstn) begin
         child_count <= '0;
      end else if (dequeued) begin
         child_count <= '0;
      end else if (task_wvalid & task_wready) begin
         child_count <= child_count + 1'b1;
      end
   end

   assign task_cq_slot = cq_slot;
   assign task_child_id = child_count;

   wdata_stable: assert property (@(posedge clk) disable iff (!rstn)
      task_wvalid && !task_wready |=> task_wvalid && $stable(task_wdata));

endmodule

`default_nettype wire

//--- design/task_sequencer.sv
`default_nettype none

module task_sequencer (
   input  logic                                       clk,
   input  logic                                       rstn,
   input  logic                                       cmd_valid,
   input  task_bridge_pkg::dbus_cmd_t                 cmd,
   input  task_bridge_pkg::mmio_target_e              target,
   input  logic                                       task_rvalid,
   input  task_bridge_pkg::task_t                     task_rdata,
   input  logic [task_bridge_pkg::SLOT_WIDTH-1:0]     task_rslot,
   input  logic [task_bridge_pkg::THREAD_WIDTH-1:0]   task_rthread,
   input  logic                                       start_task_ready,
   input  logic                                       finish_task_ready,
   input  logic                                       enq_pending,
   input  logic                                       undo_pending,
   input  logic [task_bridge_pkg::CHILD_WIDTH-1:0]    child_count,
   input  logic                                       undo_written,
   output logic                                       seq_ready,
   output logic                                       read_accept,
   output logic                                       dequeued,
   output logic [task_bridge_pkg::SLOT_WIDTH-1:0]     cq_slot,
   output logic                                       task_arvalid,
   output logic                                       start_task_valid,
   output logic [task_bridge_pkg::SLOT_WIDTH-1:0]     start_task_slot,
   output logic                                       finish_task_valid,
   output logic [task_bridge_pkg::SLOT_WIDTH-1:0]     finish_task_slot,
   output logic [task_bridge_pkg::THREAD_WIDTH-1:0]   finish_task_thread,
   output logic [task_bridge_pkg::CHILD_WIDTH-1:0]    finish_task_num_children,
   output logic                                       finish_task_undo_log_write,
   output logic                                       rsp_valid,
   output logic [31:0]                                rsp_data
);
   import task_bridge_pkg::*;

   bridge_state_e state;
   bridge_state_e state_next;
   task_t         cur_task;
   logic [31:0]   read_addr;
   logic [31:0]   cur_cycle;
   logic [31:0]   read_cycle;
   logic          read_take;

   // every read is taken only while the core is idle
   assign read_accept = (state == WAIT_CORE);
   assign read_take = read_accept & cmd_valid & !cmd.wr;

   assign task_arvalid = (state == NEXT_TASK);
   assign dequeued = task_arvalid & task_rvalid;

   assign start_task_valid = (state == INFORM_CQ);
   assign start_task_slot = cq_slot;

   // hold the finish report until outgoing enqueue and undo entries drain
   assign finish_task_valid = (state == FINISH_TASK) & !enq_pending & !undo_pending;
   assign finish_task_slot = cq_slot;
   assign finish_task_num_children = child_count;
   assign finish_task_undo_log_write = undo_written;

   always_comb begin
      case (target)
         FIELD_READ, DEQUEUE: seq_ready = read_accept;
         FINISH: seq_ready = finish_task_valid & finish_task_ready;
         default: seq_ready = 1'b0;
      endcase
   end

   always_comb begin
      state_next = state;
      case (state)
         WAIT_CORE: begin
            if (read_take) begin
               state_next = (target == DEQUEUE) ? NEXT_TASK : IO_READ;
            end else if (cmd_valid & (target == FINISH)) begin
               state_next = FINISH_TASK;
            end
         end
         NEXT_TASK: begin
            if (dequeued) begin
               state_next = INFORM_CQ;
            end
         end
         INFORM_CQ: begin
            if (start_task_ready) begin
               state_next = IO_READ;
            end
         end
         IO_READ: state_next = WAIT_CORE;
         FINISH_TASK: begin
            if (finish_task_valid & finish_task_ready) begin
               state_next = WAIT_CORE;
            end
         end
         default: state_next = WAIT_CORE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= WAIT_CORE;
      end else begin
         state <= state_next;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cur_cycle <= '0;
      end else begin
         cur_cycle <= cur_cycle + 32'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (dequeued) begin
         cur_task <= task_rdata;
         cq_slot <= task_rslot;
         finish_task_thread <= task_rthread;
      end
   end

   // cycle value is taken at acceptance, not at response
   always_ff @(posedge clk) begin
      if (read_take) begin
         read_addr <= cmd.addr;
         read_cycle <= cur_cycle;
      end
   end

   assign rsp_valid = (state == IO_READ);

   always_comb begin
      rsp_data = '0;
      if (rsp_valid) begin
         case (read_addr)
            ADDR_TASK_TS: rsp_data = cur_task.ts;
            ADDR_TASK_LOCALE: rsp_data = cur_task.locale;
            ADDR_TASK_TTYPE: rsp_data = 32'(cur_task.ttype);
            ADDR_TASK_ARG0: rsp_data = cur_task.args.half.lo;
            ADDR_TASK_ARG1: rsp_data = cur_task.args.half.hi;
            ADDR_CUR_CYCLE: rsp_data = read_cycle;
            default: rsp_data = '0;
         endcase
      end
   end

   arvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
      task_arvalid && !task_rvalid |=> task_arvalid);

   // no enqueue or undo entry may land while the finish report waits
   finish_hold: assert property (@(posedge clk) disable iff (!rstn)
      finish_task_valid && !finish_task_ready |=>
         finish_task_valid && $stable(finish_task_num_children)
         && $stable(finish_task_undo_log_write));

endmodule

`default_nettype wire

//--- design/mmio_decode.sv
`default_nettype none

module mmio_decode (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          cmd_valid,
   input  task_bridge_pkg::dbus_cmd_t    cmd,
   input  logic                          seq_ready,
   input  logic                          enq_ready,
   input  logic                          undo_ready,
   input  logic                          read_accept,
   output task_bridge_pkg::mmio_target_e target,
   output logic                          cmd_ready
);
   import task_bridge_pkg::*;

   logic unit_ready;

   always_comb begin
      target = UNMAPPED;
      if (cmd.wr) begin
         case (cmd.addr)
            ADDR_TASK_TS: target = ENQUEUE;
            ADDR_TASK_LOCALE,
            ADDR_TASK_TTYPE,
            ADDR_TASK_ARG0,
            ADDR_TASK_ARG1: target = FIELD_WRITE;
            ADDR_UNDO_ADDR: target = UNDO_ADDR;
            ADDR_UNDO_DATA: target = UNDO_DATA;
            ADDR_FINISH_TASK: target = FINISH;
            default: target = UNMAPPED;
         endcase
      end else begin
         case (cmd.addr)
            ADDR_TASK_TS: target = DEQUEUE;
            ADDR_TASK_LOCALE,
            ADDR_TASK_TTYPE,
            ADDR_TASK_ARG0,
            ADDR_TASK_ARG1,
            ADDR_CUR_CYCLE: target = FIELD_READ;
            default: target = UNMAPPED;
         endcase
      end
   end

   // owner of the target decides when the command is taken
   always_comb begin
      case (target)
         FIELD_READ, DEQUEUE, FINISH: unit_ready = seq_ready;
         FIELD_WRITE, ENQUEUE: unit_ready = enq_ready;
         UNDO_ADDR, UNDO_DATA: unit_ready = undo_ready;
         // unmapped writes are dropped at once, reads wait for the sequencer
         default: unit_ready = cmd.wr | read_accept;
      endcase
   end

   assign cmd_ready = cmd_valid & unit_ready;

   target_stable: assert property (@(posedge clk) disable iff (!rstn)
      cmd_valid && !cmd_ready |=> target == $past(target));

endmodule

`default_nettype wire

//--- design/task_bridge_pkg.sv
`default_nettype none

package task_bridge_pkg;

   // task window, top quarter of the address space
   localparam logic [31:0] ADDR_TASK_TS     = 32'hc000_0000;
   localparam logic [31:0] ADDR_TASK_LOCALE = 32'hc000_0004;
   localparam logic [31:0] ADDR_TASK_TTYPE  = 32'hc000_0008;
   localparam logic [31:0] ADDR_TASK_ARG0   = 32'hc000_000c;
   localparam logic [31:0] ADDR_TASK_ARG1   = 32'hc000_0010;
   localparam logic [31:0] ADDR_CUR_CYCLE   = 32'hc000_0014;
   localparam logic [31:0] ADDR_FINISH_TASK = 32'hc000_0018;
   localparam logic [31:0] ADDR_UNDO_ADDR   = 32'hc000_001c;
   localparam logic [31:0] ADDR_UNDO_DATA   = 32'hc000_0020;

   localparam int SLOT_WIDTH    = 6;
   localparam int THREAD_WIDTH  = 4;
   localparam int CHILD_WIDTH   = 8;
   localparam int UNDO_ID_WIDTH = 8;
   localparam int TTYPE_WIDTH   = 4;

   // the bus sees the arguments as two halves, the queue as one word
   typedef union packed {
      logic [63:0] word;
      struct packed {
         logic [31:0] hi;
         logic [31:0] lo;
      } half;
   } task_args_u;

   typedef struct packed {
      logic [31:0]            ts;
      logic [31:0]            locale;
      logic [TTYPE_WIDTH-1:0] ttype;
      task_args_u             args;
   } task_t;

   typedef struct packed {
      logic        wr;
      logic [31:0] addr;
      logic [31:0] data;
   } dbus_cmd_t;

   // unit and action selected by one data-bus command
   typedef enum logic [2:0] {
      FIELD_READ,
      DEQUEUE,
      FIELD_WRITE,
      ENQUEUE,
      UNDO_ADDR,
      UNDO_DATA,
      FINISH,
      UNMAPPED
   } mmio_target_e;

   typedef enum logic [2:0] {
      WAIT_CORE,
      NEXT_TASK,
      INFORM_CQ,
      IO_READ,
      FINISH_TASK
   } bridge_state_e;

endpackage

`default_nettype wire
